/* sram_bist_pkg.sv */
package sram_bist_pkg;

  // data width is tied to the pattern constants below
  localparam int DATA_W     = 16;
  localparam int ADDR_W_MAX = 20;

  typedef logic [ADDR_W_MAX-1:0] addr_t;
  typedef logic [DATA_W-1:0]     data_t;

  // data backgrounds in the order they are run
  typedef enum logic [2:0] {
    PAT_ZEROS = 3'd0,
    PAT_ONES  = 3'd1,
    PAT_ALT_5 = 3'd2,
    PAT_ALT_A = 3'd3,
    PAT_ADDR  = 3'd4,
    PAT_NADDR = 3'd5
  } pattern_e;

  // single word request from tester to controller
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  // read response from controller to tester
  typedef struct packed {
    data_t rdata;
  } mem_rsp_t;

  // first mismatch of a run
  typedef struct packed {
    addr_t addr;
    data_t expected;
    data_t actual;
  } fault_t;

endpackage

/* sram_pattern_gen.sv */
`timescale 1ns/1ps

module sram_pattern_gen
  import sram_bist_pkg::*;
#(
  parameter int addr_bits = 20
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     pat_first,
  input  logic     pat_next,
  input  addr_t    pat_addr,
  output data_t    pattern,
  output pattern_e pat_sel,
  output logic     pat_last
);

  // only the low addr_bits of the address are meaningful
  localparam addr_t ADDR_MASK = addr_t'((21'(1) << addr_bits) - 21'(1));

  pattern_e pat_q;
  addr_t    addr_m;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pat_q <= PAT_ZEROS;
    end else if (pat_first) begin
      pat_q <= PAT_ZEROS;
    end else if (pat_next) begin
      pat_q <= pattern_e'(pat_q + 3'd1);
    end
  end

  assign addr_m = pat_addr & ADDR_MASK;

  // data word for the current background and address
  always_comb begin
    case (pat_q)
      PAT_ZEROS: pattern = 16'h0000;
      PAT_ONES:  pattern = 16'hffff;
      PAT_ALT_5: pattern = 16'h5555;
      PAT_ALT_A: pattern = 16'haaaa;
      PAT_ADDR:  pattern = addr_m[DATA_W-1:0];
      PAT_NADDR: pattern = ~addr_m[DATA_W-1:0];
      default:   pattern = 16'h0000;
    endcase
  end

  assign pat_sel  = pat_q;
  assign pat_last = (pat_q == PAT_NADDR);

  // the tester finishes after the last background and never wraps around
  a_no_next_after_last: assert property (
    @(posedge clk) disable iff (reset) pat_next |-> !pat_last
  );

endmodule

/* sram_ctrl.sv */
`timescale 1ns/1ps

module sram_ctrl
  import sram_bist_pkg::*;
#(
  parameter int addr_bits   = 20,
  parameter int wait_states = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_valid,
  input  mem_req_t req,
  output logic     req_ready,
  output logic     rsp_valid,
  output mem_rsp_t rsp,
  output addr_t    addr_bus,
  output data_t    data_out,
  output logic     data_oe,
  input  data_t    data_in,
  output logic     ce_n,
  output logic     we_n,
  output logic     oe_n
);

  localparam addr_t ADDR_MASK = addr_t'((21'(1) << addr_bits) - 21'(1));
  localparam int    CNT_W     = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    FINISH
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] wait_cnt;
  logic             access_end;

  // last cycle of the strobe window
  assign access_end = (state == ACCESS) && (wait_cnt == '0);
  assign req_ready  = (state == IDLE);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      wait_cnt  <= '0;
      rsp_valid <= 1'b0;
      ce_n      <= 1'b1;
      we_n      <= 1'b1;
      oe_n      <= 1'b1;
      data_oe   <= 1'b0;
      addr_bus  <= '0;
      data_out  <= '0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (req_valid) begin
            // address and data stay put until the next request
            addr_bus <= req.addr & ADDR_MASK;
            data_out <= req.wdata;
            data_oe  <= req.we;
            ce_n     <= 1'b0;
            we_n     <= ~req.we;
            oe_n     <= req.we;
            wait_cnt <= CNT_W'(wait_states);
            state    <= ACCESS;
          end
        end
        ACCESS: begin
          if (access_end) begin
            ce_n      <= 1'b1;
            we_n      <= 1'b1;
            oe_n      <= 1'b1;
            data_oe   <= 1'b0;
            rsp_valid <= ~oe_n;
            state     <= FINISH;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        // one dead cycle before ready comes back
        FINISH: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // read data sampled at the end of the strobe
  always_ff @(posedge clk) begin
    if (access_end && !oe_n) begin
      rsp.rdata <= data_in;
    end
  end

  a_no_we_oe_overlap: assert property (
    @(posedge clk) disable iff (reset) !(!we_n && !oe_n)
  );

  a_oe_only_in_write: assert property (
    @(posedge clk) disable iff (reset) data_oe |-> !we_n
  );

endmodule

/* sram_tester.sv */
`timescale 1ns/1ps

module sram_tester
  import sram_bist_pkg::*;
#(
  parameter int addr_bits = 20
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     start,
  output logic     req_valid,
  output mem_req_t req,
  input  logic     req_ready,
  input  logic     rsp_valid,
  input  mem_rsp_t rsp,
  output logic     pat_first,
  output logic     pat_next,
  output addr_t    pat_addr,
  input  data_t    pattern,
  input  logic     pat_last,
  output logic     busy,
  output logic     test_done,
  output logic     test_pass,
  output fault_t   fault
);

  localparam addr_t ADDR_MAX = addr_t'((21'(1) << addr_bits) - 21'(1));

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    WAIT_RSP,
    CHECK,
    DONE
  } state_e;

  state_e state;
  addr_t  addr_q;
  logic   addr_last;
  logic   xfer;
  logic   run_start;
  logic   mismatch;

  // expected word and address of the outstanding read, and the word returned
  addr_t  exp_addr_q;
  data_t  exp_q;
  data_t  act_q;

  assign addr_last = (addr_q == ADDR_MAX);
  assign busy      = (state != IDLE) && (state != DONE);
  assign run_start = start && !busy;
  assign xfer      = req_valid && req_ready;
  assign mismatch  = (act_q != exp_q);

  assign req_valid = (state == WRITE) || (state == READ);
  assign req.we    = (state == WRITE);
  assign req.addr  = addr_q;
  assign req.wdata = pattern;
  assign pat_addr  = addr_q;

  assign pat_first = run_start;
  assign pat_next  = (state == CHECK) && !mismatch && addr_last && !pat_last;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      addr_q    <= '0;
      test_done <= 1'b0;
      test_pass <= 1'b1;
      fault     <= '0;
    end else begin
      case (state)
        IDLE, DONE: begin
          if (run_start) begin
            addr_q    <= '0;
            test_done <= 1'b0;
            test_pass <= 1'b1;
            state     <= WRITE;
          end
        end
        WRITE: begin
          if (xfer) begin
            if (addr_last) begin
              addr_q <= '0;
              state  <= READ;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        READ: begin
          if (xfer) begin
            state <= WAIT_RSP;
          end
        end
        WAIT_RSP: begin
          if (rsp_valid) begin
            state <= CHECK;
          end
        end
        CHECK: begin
          if (mismatch) begin
            fault     <= '{addr: exp_addr_q, expected: exp_q, actual: act_q};
            test_pass <= 1'b0;
            test_done <= 1'b1;
            state     <= DONE;
          end else if (!addr_last) begin
            addr_q <= addr_q + 1'b1;
            state  <= READ;
          end else if (pat_last) begin
            test_done <= 1'b1;
            state     <= DONE;
          end else begin
            // next background starts over with writes
            addr_q <= '0;
            state  <= WRITE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == READ && xfer) begin
      exp_addr_q <= addr_q;
      exp_q      <= pattern;
    end
    if (rsp_valid) begin
      act_q <= rsp.rdata;
    end
  end

  // request held until the controller takes it
  a_req_stable: assert property (
    @(posedge clk) disable iff (reset)
    req_valid && !req_ready |=> req_valid && $stable(req)
  );

endmodule

/* sram_bist_top.sv */
`timescale 1ns/1ps

module sram_bist_top
  import sram_bist_pkg::*;
#(
  parameter int addr_bits   = 20,
  parameter int wait_states = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     start,
  output logic     busy,
  output logic     test_done,
  output logic     test_pass,
  output fault_t   fault,
  output pattern_e pat_sel,
  output addr_t    addr_bus,
  output data_t    data_out,
  output logic     data_oe,
  input  data_t    data_in,
  output logic     ce_n,
  output logic     we_n,
  output logic     oe_n
);

  logic     req_valid;
  logic     req_ready;
  mem_req_t req;
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     pat_first;
  logic     pat_next;
  logic     pat_last;
  addr_t    pat_addr;
  data_t    pattern;

  sram_tester #(
    .addr_bits (addr_bits)
  ) i_sram_tester (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .pat_first (pat_first),
    .pat_next  (pat_next),
    .pat_addr  (pat_addr),
    .pattern   (pattern),
    .pat_last  (pat_last),
    .busy      (busy),
    .test_done (test_done),
    .test_pass (test_pass),
    .fault     (fault)
  );

  sram_pattern_gen #(
    .addr_bits (addr_bits)
  ) i_sram_pattern_gen (
    .clk       (clk),
    .reset     (reset),
    .pat_first (pat_first),
    .pat_next  (pat_next),
    .pat_addr  (pat_addr),
    .pattern   (pattern),
    .pat_sel   (pat_sel),
    .pat_last  (pat_last)
  );

  sram_ctrl #(
    .addr_bits   (addr_bits),
    .wait_states (wait_states)
  ) i_sram_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .addr_bus  (addr_bus),
    .data_out  (data_out),
    .data_oe   (data_oe),
    .data_in   (data_in),
    .ce_n      (ce_n),
    .we_n      (we_n),
    .oe_n      (oe_n)
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real period_ns    = 8.0,
  parameter int  reset_cycles = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  // released on a rising edge so flops see it from the next edge on
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* tb_sram_model.sv */
`timescale 1ns/1ps

module tb_sram_model
  import sram_bist_pkg::*;
#(
  parameter int addr_bits   = 6,
  parameter int wait_states = 2
) (
  input  logic       clk,
  input  logic       reset,
  input  addr_t      addr_bus,
  input  data_t      data_out,
  input  logic       data_oe,
  output data_t      data_in,
  input  logic       ce_n,
  input  logic       we_n,
  input  logic       oe_n,
  input  logic       fault_en,
  input  addr_t      fault_addr,
  input  logic [3:0] fault_bit,
  input  logic       fault_val,
  output logic       proto_err
);

  localparam int WORDS = 1 << addr_bits;

  data_t mem [WORDS];
  data_t rd_word;
  int    low_cnt;

  // power-up contents differ per address
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = data_t'(i * 257) ^ 16'hc3a5;
    end
  end

  // stored word with the stuck bit applied
  always_comb begin
    rd_word = mem[int'(addr_bus[addr_bits-1:0])];
    if (fault_en && addr_bus == fault_addr) begin
      rd_word[fault_bit] = fault_val;
    end
  end

  // the driver wins the bus, otherwise the array drives it on a read
  assign data_in = data_oe ? data_out : ((!ce_n && !oe_n) ? rd_word : '0);

  always @(posedge clk) begin
    if (reset) begin
      low_cnt   <= 0;
      proto_err <= 1'b0;
    end else begin
      if (!we_n && !oe_n) begin
        $display("SRAM model: we_n and oe_n are low together at %0t", $time);
        proto_err <= 1'b1;
      end
      if (data_oe && (we_n || ce_n)) begin
        $display("SRAM model: data_oe is high outside a write at %0t", $time);
        proto_err <= 1'b1;
      end
      if (!ce_n) begin
        low_cnt <= low_cnt + 1;
        if (!we_n) begin
          mem[int'(addr_bus[addr_bits-1:0])] <= data_out;
        end
      end else if (low_cnt != 0) begin
        if (low_cnt != 1 + wait_states) begin
          $display("SRAM model: ce_n was low for %0d cycles instead of %0d",
                   low_cnt, 1 + wait_states);
          proto_err <= 1'b1;
        end
        low_cnt <= 0;
      end
    end
  end

endmodule

/* tb_sram_bist.sv */
`timescale 1ns/1ps

module tb_sram_bist
  import sram_bist_pkg::*;
();

  localparam int ADDR_BITS   = 6;
  localparam int WAIT_STATES = 2;
  localparam int WORDS       = 1 << ADDR_BITS;
  localparam int NUM_BG      = 6;
  localparam int DONE_LIMIT  = 20000;

  logic       clk;
  logic       por_reset;
  logic       ext_reset;
  logic       reset;
  logic       start;
  logic       busy;
  logic       test_done;
  logic       test_pass;
  fault_t     fault;
  pattern_e   pat_sel;
  addr_t      addr_bus;
  data_t      data_out;
  logic       data_oe;
  data_t      data_in;
  logic       ce_n;
  logic       we_n;
  logic       oe_n;
  logic       fault_en;
  addr_t      fault_addr;
  logic [3:0] fault_bit;
  logic       fault_val;
  logic       proto_err;

  // access counters owned by the monitor
  int         wr_total = 0;
  int         rd_total = 0;
  int         wr_base;
  int         rd_base;
  int         mon_idx;
  addr_t      mon_addr;
  logic       ce_prev = 1'b1;

  // predicted result of the current run
  logic       exp_pass;
  fault_t     exp_fault;
  int         exp_wr;
  int         exp_rd;
  int         exp_bg;

  assign reset = por_reset | ext_reset;

  tb_clk_gen i_clk_gen (
    .clk   (clk),
    .reset (por_reset)
  );

  sram_bist_top #(
    .addr_bits   (ADDR_BITS),
    .wait_states (WAIT_STATES)
  ) i_sram_bist_top (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .busy      (busy),
    .test_done (test_done),
    .test_pass (test_pass),
    .fault     (fault),
    .pat_sel   (pat_sel),
    .addr_bus  (addr_bus),
    .data_out  (data_out),
    .data_oe   (data_oe),
    .data_in   (data_in),
    .ce_n      (ce_n),
    .we_n      (we_n),
    .oe_n      (oe_n)
  );

  tb_sram_model #(
    .addr_bits   (ADDR_BITS),
    .wait_states (WAIT_STATES)
  ) i_sram_model (
    .clk        (clk),
    .reset      (reset),
    .addr_bus   (addr_bus),
    .data_out   (data_out),
    .data_oe    (data_oe),
    .data_in    (data_in),
    .ce_n       (ce_n),
    .we_n       (we_n),
    .oe_n       (oe_n),
    .fault_en   (fault_en),
    .fault_addr (fault_addr),
    .fault_bit  (fault_bit),
    .fault_val  (fault_val),
    .proto_err  (proto_err)
  );

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("Error: %s at %0t", what, $time);
    stop_run();
  endtask

  task automatic check_logic(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_pattern(input string name, input pattern_e exp, input pattern_e act);
    if (act !== exp) begin
      $display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  // backgrounds in order zeros, ones, 5555, aaaa, address, inverted address
  function automatic data_t pattern_word(input int bg, input addr_t a);
    case (bg)
      0:       return 16'h0000;
      1:       return 16'hffff;
      2:       return 16'h5555;
      3:       return 16'haaaa;
      4:       return a[DATA_W-1:0];
      default: return ~a[DATA_W-1:0];
    endcase
  endfunction

  // first failing read in write-then-read order
  function automatic void predict_run();
    data_t w;
    exp_pass  = 1'b1;
    exp_fault = '0;
    exp_wr    = NUM_BG * WORDS;
    exp_rd    = NUM_BG * WORDS;
    exp_bg    = NUM_BG - 1;
    if (fault_en) begin
      for (int bg = 0; bg < NUM_BG; bg++) begin
        w = pattern_word(bg, fault_addr);
        if (exp_pass && w[fault_bit] != fault_val) begin
          exp_pass                    = 1'b0;
          exp_fault.addr              = fault_addr;
          exp_fault.expected          = w;
          exp_fault.actual            = w;
          exp_fault.actual[fault_bit] = fault_val;
          exp_wr                      = (bg + 1) * WORDS;
          exp_rd                      = bg * WORDS + int'(fault_addr) + 1;
          exp_bg                      = bg;
        end
      end
    end
  endfunction

  // watches each access as it starts
  always @(negedge clk) begin
    if (!reset) begin
      if (proto_err) report_error("SRAM model saw a pin protocol violation");
      if (!ce_n && ce_prev) begin
        if (test_done) report_error("SRAM access after test_done");
        if (!we_n) begin
          mon_idx  = wr_total - wr_base;
          mon_addr = addr_t'(mon_idx % WORDS);
          check_addr("write address", mon_addr, addr_bus);
          check_pattern("write background", pattern_e'(mon_idx / WORDS), pat_sel);
          check_data("write data", pattern_word(mon_idx / WORDS, mon_addr), data_out);
          wr_total++;
        end else begin
          check_addr("read address", addr_t'((rd_total - rd_base) % WORDS), addr_bus);
          rd_total++;
        end
      end
    end
    ce_prev = ce_n;
  end

  task automatic pulse_start();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic begin_run();
    wr_base = wr_total;
    rd_base = rd_total;
    pulse_start();
  endtask

  task automatic wait_reset_release(input int limit);
    int n;
    n = 0;
    while (reset !== 1'b0) begin
      @(posedge clk);
      #1;
      n++;
      if (n > limit) report_error("reset was never released");
    end
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (test_done !== 1'b1) begin
      @(posedge clk);
      #1;
      n++;
      if (n > limit) report_error("timeout waiting for test_done");
    end
  endtask

  task automatic check_reset_values(input string name);
    check_logic({name, " test_done"}, 1'b0, test_done);
    check_logic({name, " test_pass"}, 1'b1, test_pass);
    check_logic({name, " busy"}, 1'b0, busy);
    check_logic({name, " ce_n"}, 1'b1, ce_n);
    check_logic({name, " we_n"}, 1'b1, we_n);
    check_logic({name, " oe_n"}, 1'b1, oe_n);
    check_logic({name, " data_oe"}, 1'b0, data_oe);
    check_pattern({name, " pat_sel"}, PAT_ZEROS, pat_sel);
    check_addr({name, " fault addr"}, '0, fault.addr);
    check_data({name, " fault expected"}, '0, fault.expected);
    check_data({name, " fault actual"}, '0, fault.actual);
  endtask

  task automatic run_once(input string name, input bit use_fault);
    int idle;
    int poke;
    if (use_fault) begin
      fault_addr = addr_t'($urandom_range(0, WORDS - 1));
      fault_bit  = 4'($urandom_range(0, 15));
      fault_val  = 1'($urandom_range(0, 1));
    end
    fault_en = use_fault;
    predict_run();
    idle = $urandom_range(1, 12);
    repeat (idle) @(posedge clk);
    #1;
    begin_run();
    // a second start in the middle of the run
    poke = $urandom_range(5, 300);
    repeat (poke) @(posedge clk);
    #1;
    if (busy) pulse_start();
    wait_done(DONE_LIMIT);
    check_logic({name, " pass"}, exp_pass, test_pass);
    check_logic({name, " busy"}, 1'b0, busy);
    check_pattern({name, " last background"}, pattern_e'(exp_bg), pat_sel);
    if (!exp_pass) begin
      check_addr({name, " fault addr"}, exp_fault.addr, fault.addr);
      check_data({name, " fault expected"}, exp_fault.expected, fault.expected);
      check_data({name, " fault actual"}, exp_fault.actual, fault.actual);
    end
    repeat (20) @(posedge clk);
    #1;
    check_logic({name, " done held"}, 1'b1, test_done);
    check_count({name, " writes"}, exp_wr, wr_total - wr_base);
    check_count({name, " reads"}, exp_rd, rd_total - rd_base);
  endtask

  task automatic reset_mid_run();
    int cut;
    fault_en = 1'b0;
    begin_run();
    cut = $urandom_range(10, 2000);
    repeat (cut) @(posedge clk);
    #1;
    ext_reset = 1'b1;
    @(posedge clk);
    #1;
    check_reset_values("reset during run");
    repeat (3) @(posedge clk);
    #1;
    ext_reset = 1'b0;
  endtask

  initial begin
    start      = 1'b0;
    ext_reset  = 1'b0;
    fault_en   = 1'b0;
    fault_addr = '0;
    fault_bit  = '0;
    fault_val  = 1'b0;
    wr_base    = 0;
    rd_base    = 0;
    void'($urandom(32'h32216a3e));
    @(posedge clk);
    #1;
    wait_reset_release(20);
    check_reset_values("after reset");
    run_once("clean run", 1'b0);
    run_once("stuck bit run", 1'b1);
    for (int i = 0; i < 6; i++) begin
      run_once($sformatf("random run %0d", i), 1'($urandom_range(0, 1)));
    end
    reset_mid_run();
    run_once("run after reset", 1'b0);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* sim.f */
sram_bist_pkg.sv
sram_pattern_gen.sv
sram_ctrl.sv
sram_tester.sv
sram_bist_top.sv
tb_clk_gen.sv
tb_sram_model.sv
tb_sram_bist.sv

/* Makefile */
# Verilator build and run for the SRAM BIST testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_bist
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TB PASSED
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
